//--- files.f
+incdir+tb
verilog/wb_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/wb_slave_decoder.sv
verilog/line_ram.sv
verilog/ram_burst_adapter.sv
verilog/clint_regs.sv
verilog/wb_mem_subsys.sv
tb/tb_wb_mem_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it, grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_mem_subsys \
  -f files.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/tb_bus_tasks.svh
// Wishbone master tasks, value check, RAM word model and CLINT shadow registers

// ========================================
// Reference model
// ========================================
logic [31:0] ram_model [soc_map_pkg::RAM_WORDS];
logic [63:0] mtimecmp_model = '1;
logic        msip_model     = 1'b0;

int err_count   = 0;
int check_count = 0;

// Byte lanes picked by a select field
function automatic logic [31:0] byte_mask(input logic [3:0] sel);
  return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
endfunction

task automatic model_write(input int idx, input logic [31:0] dat, input logic [3:0] sel);
  logic [31:0] m;
  m = byte_mask(sel);
  ram_model[idx] = (ram_model[idx] & ~m) | (dat & m);
endtask

// Compare and count with one ERR line per mismatch
task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
  end
endtask

// ========================================
// Bus master
// ========================================
// One beat driven on the falling edge with the ack looked at 1 unit later
task automatic bus_beat(
  input  logic [31:0] adr,
  input  logic        we,
  input  logic [31:0] dat,
  input  logic [3:0]  sel,
  input  logic [2:0]  cti,
  output logic [31:0] rdata,
  output int          waited
);
  @(negedge clk_i);
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = we;
  wb_adr_i = adr;
  wb_dat_i = dat;
  wb_sel_i = sel;
  wb_cti_i = cti;
  #1;
  waited = 0;
  while (!wb_ack_o && waited < ACK_LIMIT) begin
    @(negedge clk_i);
    #1;
    waited++;
  end
  rdata = wb_dat_o;
  if (!wb_ack_o) begin
    err_count++;
    $display("No ack within %0d cycles for the access at address 0x%08h", ACK_LIMIT, adr);
  end
endtask

// Strobe low for the cycle after the last beat
task automatic bus_idle();
  @(negedge clk_i);
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
  wb_cti_i = wb_bus_pkg::CTI_CLASSIC;
endtask

// Classic cycle with a check of the ack delay
task automatic single_access(
  input  string       name,
  input  logic [31:0] adr,
  input  logic        we,
  input  logic [31:0] dat,
  input  logic [3:0]  sel,
  input  int          exp_wait,
  output logic [31:0] rdata
);
  int waited;
  bus_beat(adr, we, dat, sel, wb_bus_pkg::CTI_CLASSIC, rdata, waited);
  check_val({name, " ack delay"}, exp_wait, waited);
  bus_idle();
endtask

//--- tb/tb_wb_mem_subsys.sv
// Testbench for the memory subsystem with clock, reset, watchdog, tests and summary
`default_nettype none

module tb_wb_mem_subsys;

  localparam int N_RAND    = 200;
  localparam int N_BURST   = 40;
  localparam int IRQ_WAIT  = 100;
  localparam int ACK_LIMIT = 4 * wb_bus_pkg::RAM_LATENCY;
  localparam int RD_WAIT   = wb_bus_pkg::RAM_LATENCY + 1;
  // Bus accesses and idle waits of all tests
  localparam int TEST_LEN = 4 + soc_map_pkg::RAM_WORDS + 2 * N_RAND
                          + N_BURST * wb_bus_pkg::WORDS_PER_LINE + 6 + 8 + IRQ_WAIT + 2;
  localparam int WATCHDOG_CYCLES = TEST_LEN * 20;

  logic        clk_i;
  logic        rst_ni;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [2:0]  wb_cti_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        timer_irq_o;
  logic        sw_irq_o;

  string cur_test;
  int    test_err_base;
  int    tests_done = 0;

  `include "tb_bus_tasks.svh"

  wb_mem_subsys wb_mem_subsys_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_cti_i   (wb_cti_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] clint_adr(input logic [15:0] ofs);
    return {soc_map_pkg::CLINT_BASE[31:16], ofs};
  endfunction

  // Fill word built from every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return {adr[15:0], adr[31:16]} ^ (adr * 32'h9E37_79B1);
  endfunction

  task automatic begin_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
  endtask

  task automatic end_test();
    tests_done++;
    $display("[%0d] %s finished with %0d error(s)", tests_done, cur_test,
             err_count - test_err_base);
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [31:0] rdata;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic [63:0] target;
    int          idx;
    int          line;
    int          waited;
    int          irq_cycles;
    void'($urandom(85));
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_cti_i = wb_bus_pkg::CTI_CLASSIC;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle outputs and compare register reset value
    begin_test("reset_state");
    @(negedge clk_i);
    check_val("reset ack", 0, wb_ack_o);
    check_val("reset timer_irq", 0, timer_irq_o);
    check_val("reset sw_irq", 0, sw_irq_o);
    single_access("mtimecmp_lo", clint_adr(soc_map_pkg::MTIMECMP_LO_OFS), 0, 0, 4'hF, 1,
                  rdata);
    check_val("mtimecmp_lo reset", mtimecmp_model[31:0], rdata);
    single_access("mtimecmp_hi", clint_adr(soc_map_pkg::MTIMECMP_HI_OFS), 0, 0, 4'hF, 1,
                  rdata);
    check_val("mtimecmp_hi reset", mtimecmp_model[63:32], rdata);
    end_test();

    // Fill then random byte writes and random reads
    begin_test("ram_random");
    for (idx = 0; idx < soc_map_pkg::RAM_WORDS; idx++) begin
      adr = soc_map_pkg::RAM_BASE + 32'(idx * 4);
      dat = fill_word(adr);
      single_access("ram fill", adr, 1, dat, 4'hF, 0, rdata);
      model_write(idx, dat, 4'hF);
    end
    repeat (N_RAND) begin
      idx = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
      dat = $urandom;
      sel = 4'($urandom_range(0, 15));
      single_access("ram write", soc_map_pkg::RAM_BASE + 32'(idx * 4), 1, dat, sel, 0, rdata);
      model_write(idx, dat, sel);
    end
    repeat (N_RAND) begin
      idx = $urandom_range(0, soc_map_pkg::RAM_WORDS - 1);
      single_access("ram read", soc_map_pkg::RAM_BASE + 32'(idx * 4), 0, 0, 4'hF, RD_WAIT,
                    rdata);
      check_val("ram read data", ram_model[idx], rdata);
    end
    end_test();

    // Incrementing 4-beat line bursts
    begin_test("ram_burst");
    repeat (N_BURST) begin
      line = $urandom_range(0, soc_map_pkg::RAM_LINES - 1);
      for (int b = 0; b < wb_bus_pkg::WORDS_PER_LINE; b++) begin
        idx = line * wb_bus_pkg::WORDS_PER_LINE + b;
        bus_beat(soc_map_pkg::RAM_BASE + 32'(idx * 4), 0, 0, 4'hF,
                 (b == wb_bus_pkg::WORDS_PER_LINE - 1) ? wb_bus_pkg::CTI_EOB
                                                       : wb_bus_pkg::CTI_INCR,
                 rdata, waited);
        check_val("burst beat data", ram_model[idx], rdata);
        // Only the first beat goes to the array
        check_val("burst beat ack delay", (b == 0) ? RD_WAIT : 0, waited);
      end
      bus_idle();
    end
    end_test();

    // Software interrupt
    begin_test("clint_msip");
    single_access("msip set", clint_adr(soc_map_pkg::MSIP_OFS), 1, 32'h1, 4'hF, 1, rdata);
    msip_model = 1'b1;
    check_val("sw_irq after set", msip_model, sw_irq_o);
    single_access("msip read", clint_adr(soc_map_pkg::MSIP_OFS), 0, 0, 4'hF, 1, rdata);
    check_val("msip readback", {31'h0, msip_model}, rdata);
    single_access("msip clear", clint_adr(soc_map_pkg::MSIP_OFS), 1, 32'h0, 4'hF, 1, rdata);
    msip_model = 1'b0;
    check_val("sw_irq after clear", msip_model, sw_irq_o);
    end_test();

    // Timer compare
    begin_test("clint_timer");
    single_access("cmp lo far", clint_adr(soc_map_pkg::MTIMECMP_LO_OFS), 1, 0, 4'hF, 1, rdata);
    mtimecmp_model[31:0] = 32'h0;
    single_access("cmp hi far", clint_adr(soc_map_pkg::MTIMECMP_HI_OFS), 1, 1, 4'hF, 1, rdata);
    mtimecmp_model[63:32] = 32'h1;
    check_val("timer_irq with far compare", 0, timer_irq_o);
    single_access("mtime lo", clint_adr(soc_map_pkg::MTIME_LO_OFS), 0, 0, 4'hF, 1, rdata);
    target[31:0] = rdata;
    single_access("mtime hi", clint_adr(soc_map_pkg::MTIME_HI_OFS), 0, 0, 4'hF, 1, rdata);
    target[63:32] = rdata;
    target = target + 64'd50;
    // Low half first keeps the compare ahead of the timer
    single_access("cmp lo near", clint_adr(soc_map_pkg::MTIMECMP_LO_OFS), 1, target[31:0],
                  4'hF, 1, rdata);
    single_access("cmp hi near", clint_adr(soc_map_pkg::MTIMECMP_HI_OFS), 1, target[63:32],
                  4'hF, 1, rdata);
    mtimecmp_model = target;
    check_val("timer_irq before compare", 0, timer_irq_o);
    irq_cycles = 0;
    while (!timer_irq_o && irq_cycles < IRQ_WAIT) begin
      @(negedge clk_i);
      irq_cycles++;
    end
    if (!timer_irq_o) begin
      err_count++;
      $display("Timer interrupt did not rise within %0d cycles", IRQ_WAIT);
    end
    single_access("cmp readback", clint_adr(soc_map_pkg::MTIMECMP_LO_OFS), 0, 0, 4'hF, 1,
                  rdata);
    check_val("mtimecmp_lo readback", mtimecmp_model[31:0], rdata);
    end_test();

    // Peripheral window and a hole
    begin_test("unmapped");
    adr = soc_map_pkg::PERIPH_BASE | ($urandom & 32'h0FFF_FFFC);
    single_access("periph read", adr, 0, 0, 4'hF, 0, rdata);
    check_val("periph read data", 0, rdata);
    single_access("hole read", 32'hC000_0010, 0, 0, 4'hF, 0, rdata);
    check_val("hole read data", 0, rdata);
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, check_count, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/wb_mem_subsys.sv
// Memory subsystem top with decoder, RAM burst path and CLINT on one Wishbone slave port
`default_nettype none

module wb_mem_subsys (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] wb_dat_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0] wb_sel_i,
  input  logic [wb_bus_pkg::WB_CTI_W-1:0] wb_cti_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0] wb_dat_o,
  output logic                            wb_ack_o,
  output logic                            timer_irq_o,
  output logic                            sw_irq_o
);

  // Target strobes and responses
  logic                            ram_stb;
  logic                            ram_ack;
  logic [wb_bus_pkg::WB_DAT_W-1:0] ram_dat;
  logic                            clint_stb;
  logic                            clint_ack;
  logic [wb_bus_pkg::WB_DAT_W-1:0] clint_dat;

  // ======================================
  // Address decode
  // ======================================
  wb_slave_decoder i_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cyc_i      (wb_cyc_i),
    .stb_i      (wb_stb_i),
    .adr_i      (wb_adr_i),
    .ram_ack_i  (ram_ack),
    .ram_dat_i  (ram_dat),
    .clint_ack_i(clint_ack),
    .clint_dat_i(clint_dat),
    .ram_stb_o  (ram_stb),
    .clint_stb_o(clint_stb),
    .ack_o      (wb_ack_o),
    .dat_o      (wb_dat_o)
  );

  // Main RAM path
  ram_burst_adapter i_ram_path (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .stb_i (ram_stb),
    .we_i  (wb_we_i),
    .adr_i (wb_adr_i),
    .dat_i (wb_dat_i),
    .sel_i (wb_sel_i),
    .cti_i (wb_cti_i),
    .dat_o (ram_dat),
    .ack_o (ram_ack)
  );

  // Timer and software interrupt
  clint_regs i_clint (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .stb_i      (clint_stb),
    .we_i       (wb_we_i),
    .adr_i      (wb_adr_i),
    .dat_i      (wb_dat_i),
    .sel_i      (wb_sel_i),
    .dat_o      (clint_dat),
    .ack_o      (clint_ack),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

endmodule

`default_nettype wire

//--- verilog/clint_regs.sv
// CLINT registers with machine timer, timer compare, software interrupt bit and IRQ lines
`default_nettype none

module clint_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] adr_i,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] dat_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0] sel_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0] dat_o,
  output logic                            ack_o,
  output logic                            timer_irq_o,
  output logic                            sw_irq_o
);

  logic [soc_map_pkg::MTIME_W-1:0]     mtime_q;
  logic [soc_map_pkg::MTIME_W-1:0]     mtime_nxt;
  logic [soc_map_pkg::MTIME_W-1:0]     mtimecmp_q;
  logic                                msip_q;
  logic                                ack_q;
  logic [wb_bus_pkg::WB_DAT_W-1:0]     dat_q;
  logic [wb_bus_pkg::WB_DAT_W-1:0]     rdata;
  logic [soc_map_pkg::CLINT_OFS_W-1:0] ofs;
  logic                                access;
  logic                                wr_en;

  // Byte-lane merge of a write into a 32-bit half
  function automatic logic [wb_bus_pkg::WB_DAT_W-1:0] merge_bytes(
    input logic [wb_bus_pkg::WB_DAT_W-1:0] old_val,
    input logic [wb_bus_pkg::WB_DAT_W-1:0] new_val,
    input logic [wb_bus_pkg::WB_SEL_W-1:0] sel
  );
    logic [wb_bus_pkg::WB_DAT_W-1:0] res;
    res = old_val;
    for (int b = 0; b < wb_bus_pkg::WB_SEL_W; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // First cycle of each access only
  assign access = stb_i & ~ack_q;
  assign wr_en  = access & we_i;
  assign ofs    = adr_i[soc_map_pkg::CLINT_OFS_W-1:0];

  // ======================================
  // Free running timer
  // ======================================
  // Half writes override the increment
  always_comb begin
    mtime_nxt = mtime_q + 1'b1;
    if (wr_en && ofs == soc_map_pkg::MTIME_LO_OFS) begin
      mtime_nxt[wb_bus_pkg::WB_DAT_W-1:0] =
        merge_bytes(mtime_q[wb_bus_pkg::WB_DAT_W-1:0], dat_i, sel_i);
    end
    if (wr_en && ofs == soc_map_pkg::MTIME_HI_OFS) begin
      mtime_nxt[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W] =
        merge_bytes(mtime_q[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W], dat_i, sel_i);
    end
  end

  // Read mux
  always_comb begin
    case (ofs)
      soc_map_pkg::MSIP_OFS:        rdata = {{(wb_bus_pkg::WB_DAT_W-1){1'b0}}, msip_q};
      soc_map_pkg::MTIMECMP_LO_OFS: rdata = mtimecmp_q[wb_bus_pkg::WB_DAT_W-1:0];
      soc_map_pkg::MTIMECMP_HI_OFS:
        rdata = mtimecmp_q[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W];
      soc_map_pkg::MTIME_LO_OFS:    rdata = mtime_q[wb_bus_pkg::WB_DAT_W-1:0];
      soc_map_pkg::MTIME_HI_OFS:    rdata = mtime_q[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W];
      default:                      rdata = '0;
    endcase
  end

  // ======================================
  // Register file
  // ======================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_nxt;
      ack_q   <= access;
      if (wr_en && ofs == soc_map_pkg::MTIMECMP_LO_OFS) begin
        mtimecmp_q[wb_bus_pkg::WB_DAT_W-1:0] <=
          merge_bytes(mtimecmp_q[wb_bus_pkg::WB_DAT_W-1:0], dat_i, sel_i);
      end
      if (wr_en && ofs == soc_map_pkg::MTIMECMP_HI_OFS) begin
        mtimecmp_q[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W] <=
          merge_bytes(mtimecmp_q[soc_map_pkg::MTIME_W-1:wb_bus_pkg::WB_DAT_W], dat_i, sel_i);
      end
      // Only bit 0 of msip is implemented
      if (wr_en && ofs == soc_map_pkg::MSIP_OFS && sel_i[0]) begin
        msip_q <= dat_i[0];
      end
    end
  end

  // Read data registered with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rdata;
    end
  end

  assign dat_o       = dat_q;
  assign ack_o       = ack_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

`default_nettype wire

//--- verilog/ram_burst_adapter.sv
// RAM adapter with word to line conversion, burst line buffer and ack timing
`default_nettype none

module ram_burst_adapter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            stb_i,
  input  logic                            we_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] adr_i,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] dat_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0] sel_i,
  input  logic [wb_bus_pkg::WB_CTI_W-1:0] cti_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0] dat_o,
  output logic                            ack_o
);

  logic [soc_map_pkg::LINE_IDX_W-1:0]   line_idx;
  logic [wb_bus_pkg::WORD_OFS_W-1:0]    word_ofs;
  logic [wb_bus_pkg::LINE_W-1:0]        wdata_line;
  logic [wb_bus_pkg::LINE_STRB_W-1:0]   wstrb_line;
  logic [wb_bus_pkg::LINE_W-1:0]        rdata_line;
  logic                                 rd_en;
  logic                                 rvalid;
  // Line buffer and its state
  logic [wb_bus_pkg::LINE_W-1:0]        buf_q;
  logic                                 buf_vld_q;
  logic                                 pend_q;
  logic                                 wr_ack;
  logic                                 rd_ack;
  logic                                 last_beat;

  // ======================================
  // Address split and write expansion
  // ======================================
  assign line_idx = adr_i[wb_bus_pkg::LINE_LSB +: soc_map_pkg::LINE_IDX_W];
  assign word_ofs = adr_i[wb_bus_pkg::WORD_LSB +: wb_bus_pkg::WORD_OFS_W];

  // Same word in every slot, strobes pick the slot
  assign wdata_line = {wb_bus_pkg::WORDS_PER_LINE{dat_i}};

  always_comb begin
    wstrb_line = '0;
    if (stb_i && we_i) begin
      wstrb_line[word_ofs*wb_bus_pkg::WB_SEL_W +: wb_bus_pkg::WB_SEL_W] = sel_i;
    end
  end

  // One line read per transfer, only when nothing is buffered or pending
  assign rd_en = stb_i & ~we_i & ~buf_vld_q & ~pend_q;

  // ======================================
  // Ack generation
  // ======================================
  // Writes complete at once, reads once the line is buffered
  assign wr_ack    = stb_i & we_i;
  assign rd_ack    = stb_i & ~we_i & buf_vld_q;
  assign ack_o     = wr_ack | rd_ack;
  assign last_beat = (cti_i == wb_bus_pkg::CTI_EOB) || (cti_i == wb_bus_pkg::CTI_CLASSIC);

  // Beat word from the buffered line
  assign dat_o = buf_q[word_ofs*wb_bus_pkg::WB_DAT_W +: wb_bus_pkg::WB_DAT_W];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      buf_vld_q <= 1'b0;
    end else begin
      if (rd_en) begin
        pend_q <= 1'b1;
      end else if (rvalid) begin
        pend_q <= 1'b0;
      end
      if (rvalid) begin
        buf_vld_q <= 1'b1;
      end else if (rd_ack && last_beat) begin
        buf_vld_q <= 1'b0;
      end else if (!stb_i) begin
        // Strobe never gaps inside a burst, so a gap ends it
        buf_vld_q <= 1'b0;
      end
    end
  end

  // Line capture
  always_ff @(posedge clk_i) begin
    if (rvalid) begin
      buf_q <= rdata_line;
    end
  end

  line_ram i_line_ram (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .line_idx_i(line_idx),
    .wdata_i   (wdata_line),
    .wstrb_i   (wstrb_line),
    .rd_en_i   (rd_en),
    .rdata_o   (rdata_line),
    .rvalid_o  (rvalid)
  );

  // Line data only comes back for a read that was issued
  a_rvalid_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid |-> pend_q
  );

endmodule

`default_nettype wire

//--- verilog/line_ram.sv
// Line-wide RAM array with byte-strobed writes and a fixed-latency read pipeline
`default_nettype none

module line_ram (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [soc_map_pkg::LINE_IDX_W-1:0]    line_idx_i,
  input  logic [wb_bus_pkg::LINE_W-1:0]         wdata_i,
  input  logic [wb_bus_pkg::LINE_STRB_W-1:0]    wstrb_i,
  input  logic                                  rd_en_i,
  output logic [wb_bus_pkg::LINE_W-1:0]         rdata_o,
  output logic                                  rvalid_o
);

  // Storage, one entry per cache line
  logic [wb_bus_pkg::LINE_W-1:0]      mem_q     [soc_map_pkg::RAM_LINES];
  // Read data and valid delay stages
  logic [wb_bus_pkg::LINE_W-1:0]      rd_pipe_q [wb_bus_pkg::RAM_LATENCY];
  logic [wb_bus_pkg::RAM_LATENCY-1:0] vld_pipe_q;

  // ======================================
  // Byte-strobed write
  // ======================================
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < wb_bus_pkg::LINE_STRB_W; b++) begin
      if (wstrb_i[b]) begin
        mem_q[line_idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // ======================================
  // Read latency pipeline
  // ======================================
  // Stage 0 samples the array on a read, later stages just shift
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_pipe_q[0] <= mem_q[line_idx_i];
    end
    for (int s = 1; s < wb_bus_pkg::RAM_LATENCY; s++) begin
      rd_pipe_q[s] <= rd_pipe_q[s-1];
    end
  end

  // Valid marker travels alongside the data
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      vld_pipe_q <= '0;
    end else begin
      vld_pipe_q <= {vld_pipe_q[wb_bus_pkg::RAM_LATENCY-2:0], rd_en_i};
    end
  end

  assign rdata_o  = rd_pipe_q[wb_bus_pkg::RAM_LATENCY-1];
  assign rvalid_o = vld_pipe_q[wb_bus_pkg::RAM_LATENCY-1];

  // The requester keeps one line read outstanding at a time
  a_single_read : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_en_i |-> (vld_pipe_q == '0)
  );

endmodule

`default_nettype wire

//--- verilog/wb_slave_decoder.sv
// Wishbone slave decoder with region select, target strobes, ack and read data return
`default_nettype none

module wb_slave_decoder (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cyc_i,
  input  logic                            stb_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] adr_i,
  input  logic                            ram_ack_i,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] ram_dat_i,
  input  logic                            clint_ack_i,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] clint_dat_i,
  output logic                            ram_stb_o,
  output logic                            clint_stb_o,
  output logic                            ack_o,
  output logic [wb_bus_pkg::WB_DAT_W-1:0] dat_o
);

  logic [soc_map_pkg::REGION_MSB-soc_map_pkg::REGION_LSB:0] region;
  logic                                                   req;
  logic                                                   hit_ram;
  logic                                                   hit_clint;

  // Valid bus request
  assign req    = cyc_i & stb_i;
  assign region = adr_i[soc_map_pkg::REGION_MSB:soc_map_pkg::REGION_LSB];

  // Region compare against the map
  assign hit_ram   = (region ==
                      soc_map_pkg::RAM_BASE[soc_map_pkg::REGION_MSB:soc_map_pkg::REGION_LSB]);
  assign hit_clint = (region ==
                      soc_map_pkg::CLINT_BASE[soc_map_pkg::REGION_MSB:soc_map_pkg::REGION_LSB]);

  assign ram_stb_o   = req & hit_ram;
  assign clint_stb_o = req & hit_clint;

  // ======================================
  // Response return
  // ======================================
  always_comb begin
    if (hit_ram) begin
      ack_o = ram_ack_i;
      dat_o = ram_dat_i;
    end else if (hit_clint) begin
      ack_o = clint_ack_i;
      dat_o = clint_dat_i;
    end else begin
      // Peripheral window or hole answered here at once
      ack_o = req;
      dat_o = '0;
    end
  end

  // A target ack never outlives the request it answers
  a_ack_in_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> req
  );

endmodule

`default_nettype wire

//--- verilog/soc_map_pkg.sv
// SoC address map, CLINT register offsets and RAM size
`default_nettype none

package soc_map_pkg;

  // ======================================
  // Region bases
  // ======================================
  localparam logic [31:0] RAM_BASE    = 32'h8000_0000;
  localparam logic [31:0] CLINT_BASE  = 32'h3000_0000;
  localparam logic [31:0] PERIPH_BASE = 32'h2000_0000;

  // Top nibble picks the region
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  // RAM size
  localparam int RAM_WORDS  = 1024;
  localparam int RAM_LINES  = 256;
  localparam int LINE_IDX_W = $clog2(RAM_LINES);

  // ======================================
  // CLINT registers
  // ======================================
  localparam int CLINT_OFS_W = 16;
  localparam logic [CLINT_OFS_W-1:0] MSIP_OFS        = 16'h0000;
  localparam logic [CLINT_OFS_W-1:0] MTIMECMP_LO_OFS = 16'h4000;
  localparam logic [CLINT_OFS_W-1:0] MTIMECMP_HI_OFS = 16'h4004;
  localparam logic [CLINT_OFS_W-1:0] MTIME_LO_OFS    = 16'hBFF8;
  localparam logic [CLINT_OFS_W-1:0] MTIME_HI_OFS    = 16'hBFFC;
  localparam int MTIME_W = 64;

endpackage

`default_nettype wire

//--- verilog/wb_bus_pkg.sv
// Wishbone bus widths, cycle type codes, cache line geometry and RAM latency
`default_nettype none

package wb_bus_pkg;

  // ======================================
  // Bus widths
  // ======================================
  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;
  localparam int WB_CTI_W = 3;

  // B4 cycle type identifiers
  localparam logic [WB_CTI_W-1:0] CTI_CLASSIC = 3'd0;
  localparam logic [WB_CTI_W-1:0] CTI_INCR    = 3'd2;
  localparam logic [WB_CTI_W-1:0] CTI_EOB     = 3'd7;

  // ======================================
  // Cache line geometry
  // ======================================
  localparam int LINE_W         = 128;
  localparam int LINE_STRB_W    = LINE_W / 8;
  localparam int WORDS_PER_LINE = LINE_W / WB_DAT_W;

  // Word offset sits above the byte lane bits
  localparam int WORD_LSB   = $clog2(WB_SEL_W);
  localparam int WORD_OFS_W = $clog2(WORDS_PER_LINE);
  localparam int LINE_LSB   = WORD_LSB + WORD_OFS_W;

  // Cycles from line read enable to read valid
  localparam int RAM_LATENCY = 4;

endpackage

`default_nettype wire
